/* Makefile */
# Verilator build for the memory subsystem testbench.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
FLIST      ?= flist.f
TOP        ?= tb_mem_subsystem
RTL_TOP    ?= mem_subsystem
BUILD_DIR  ?= build
LOG        ?= sim.log
PASS_MSG   ?= Simulation passed
SIM_FLAGS  ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell cat $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "run passed" || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/arb_pkg.sv */
// Master count, outstanding-request limit and index types for the arbiter.
package arb_pkg;

  localparam int NUM_MASTERS = 3; // masters sharing the bank
  localparam int QUEUE_DEPTH = 4; // max requests in flight

  localparam int IDX_W  = $clog2(NUM_MASTERS);
  localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1); // fill count 0..QUEUE_DEPTH

  typedef logic [IDX_W-1:0] master_idx_t; // which master owns a request

endpackage : arb_pkg

/* common/mem_pkg.sv */
// Memory word and address types shared by the bank, the arbiter and the top level.
// Import with mem_pkg::* wherever a word or an address is carried.
package mem_pkg;

  localparam int ADDR_W = 8;  // word address bits
  localparam int DATA_W = 32; // bits per word

  // one word per address
  localparam int MEM_WORDS = 2 ** ADDR_W;

  typedef logic [ADDR_W-1:0] addr_t; // word address
  typedef logic [DATA_W-1:0] data_t; // data word

endpackage : mem_pkg

/* flist.f */
common/mem_pkg.sv
common/arb_pkg.sv
mem_arbiter/order_queue.sv
mem_arbiter/mem_arbiter.sv
source/mem_bank.sv
source/mem_subsystem.sv
verif/tb_clk_gen.sv
verif/tb_mem_subsystem.sv

/* mem_arbiter/mem_arbiter.sv */
// Fixed-priority arbiter in front of the memory bank, lowest master index wins.
// Grant indices go into an order queue that routes each bank response back.
`timescale 1ns/1ps

module mem_arbiter
  import mem_pkg::*;
  import arb_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,

  // master request side
  input  logic [NUM_MASTERS-1:0] m_req_valid,
  input  addr_t                  m_req_addr  [NUM_MASTERS],
  input  logic                   m_req_we    [NUM_MASTERS],
  input  data_t                  m_req_wdata [NUM_MASTERS],
  output logic [NUM_MASTERS-1:0] m_req_ready,

  // master response side
  output logic [NUM_MASTERS-1:0] m_resp_valid,
  output data_t                  m_resp_data,  // shared by all masters
  input  logic [NUM_MASTERS-1:0] m_resp_ready,

  // bank request side
  output logic                   bank_req_valid,
  output addr_t                  bank_req_addr,
  output logic                   bank_req_we,
  output data_t                  bank_req_wdata,
  input  logic                   bank_req_ready,

  // bank response side
  input  logic                   bank_resp_valid,
  input  data_t                  bank_resp_data,
  output logic                   bank_resp_ready
);

  master_idx_t sel;        // granted master
  logic        has_req;    // some master is waiting
  logic        req_fire;   // bank takes a request this cycle

  logic        enq_valid;
  master_idx_t enq_idx;
  logic        enq_ready;
  logic        deq_valid;
  master_idx_t deq_idx;
  logic        deq_ready;

  logic [NUM_MASTERS-1:0] route_hit; // one-hot owner of the head response

  order_queue i_order_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .enq_valid (enq_valid),
    .enq_idx   (enq_idx),
    .enq_ready (enq_ready),
    .deq_valid (deq_valid),
    .deq_idx   (deq_idx),
    .deq_ready (deq_ready)
  );

  // scan from the top so the lowest valid index is left in sel
  always_comb begin
    sel     = '0;
    has_req = 1'b0;
    for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
      if (m_req_valid[i]) begin
        sel     = master_idx_t'(i);
        has_req = 1'b1;
      end
    end
  end

  assign bank_req_valid = has_req && enq_ready; // wait while queue is full
  assign bank_req_addr  = m_req_addr[sel];
  assign bank_req_we    = m_req_we[sel];
  assign bank_req_wdata = m_req_wdata[sel];

  assign req_fire  = bank_req_valid && bank_req_ready;
  assign enq_valid = req_fire;                   // record winner on same edge
  assign enq_idx   = sel;

  for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
    assign m_req_ready[i]  = req_fire && (sel == master_idx_t'(i));
    assign route_hit[i]    = deq_valid && (deq_idx == master_idx_t'(i));
    assign m_resp_valid[i] = bank_resp_valid && route_hit[i];
  end

  assign m_resp_data     = bank_resp_data;
  assign bank_resp_ready = |(route_hit & m_resp_ready); // owner's ready only
  assign deq_ready       = bank_resp_valid && bank_resp_ready; // pop on transfer

endmodule : mem_arbiter

/* mem_arbiter/order_queue.sv */
// Fall-through FIFO of master indices, one entry per outstanding bank request.
// The head entry is visible on deq_idx as soon as the queue is non-empty.
`timescale 1ns/1ps

module order_queue
  import arb_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,

  input  logic        enq_valid,
  input  master_idx_t enq_idx,
  output logic        enq_ready,

  output logic        deq_valid,
  output master_idx_t deq_idx,
  input  logic        deq_ready
);

  typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;

  master_idx_t       entries [QUEUE_DEPTH];
  ptr_t              wr_ptr;
  ptr_t              rd_ptr;
  logic [QCNT_W-1:0] count;   // entries in use
  logic              enq_fire;
  logic              deq_fire;

  assign enq_ready = (count != QCNT_W'(QUEUE_DEPTH));
  assign deq_valid = (count != '0);
  assign deq_idx   = entries[rd_ptr]; // head shows through

  assign enq_fire = enq_valid && enq_ready;
  assign deq_fire = deq_valid && deq_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // both or neither
      endcase
    end
  end

  // storage only, validity comes from count
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      entries[wr_ptr] <= enq_idx;
    end
  end

endmodule : order_queue

/* source/mem_bank.sv */
// Single-port memory bank as a two-stage pipeline with response back-pressure.
// Reads return the stored word, writes return their own data as acknowledgement.
`timescale 1ns/1ps

module mem_bank
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,

  // request side
  input  logic  req_valid,
  input  addr_t req_addr,
  input  logic  req_we,
  input  data_t req_wdata,
  output logic  req_ready,

  // response side
  output logic  resp_valid,
  output data_t resp_data,
  input  logic  resp_ready
);

  data_t mem_array [MEM_WORDS];

  // stage 1, registered request
  logic  s1_valid;
  addr_t s1_addr;
  logic  s1_we;
  data_t s1_wdata;

  // stage 2, response held until it transfers
  logic  s2_valid;
  data_t s2_data;

  logic  stall;     // response waiting on the arbiter
  logic  req_fire;
  logic  s1_move;   // stage 1 hands over to stage 2

  assign stall     = s2_valid && !resp_ready;
  assign req_ready = !(stall && s1_valid); // empty stage 1 may still fill
  assign req_fire  = req_valid && req_ready;
  assign s1_move   = s1_valid && !stall;

  assign resp_valid = s2_valid;
  assign resp_data  = s2_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else if (req_fire) begin
      s1_valid <= 1'b1;
    end else if (s1_move) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      s1_addr  <= req_addr;
      s1_we    <= req_we;
      s1_wdata <= req_wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else if (!stall) begin
      s2_valid <= s1_valid;
    end
  end

  // array access happens as the request enters stage 2
  always_ff @(posedge clk) begin
    if (s1_move) begin
      if (s1_we) begin
        mem_array[s1_addr] <= s1_wdata;
        s2_data            <= s1_wdata;   // write echoes its data
      end else begin
        s2_data            <= mem_array[s1_addr];
      end
    end
  end

endmodule : mem_bank

/* source/mem_subsystem.sv */
// Top level of the memory subsystem, masters share one bank through the arbiter.
// Only wiring between the arbiter and the bank lives here.
`timescale 1ns/1ps

module mem_subsystem
  import mem_pkg::*;
  import arb_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,

  // master requests
  input  logic [NUM_MASTERS-1:0] m_req_valid,
  input  addr_t                  m_req_addr  [NUM_MASTERS],
  input  logic                   m_req_we    [NUM_MASTERS],
  input  data_t                  m_req_wdata [NUM_MASTERS],
  output logic [NUM_MASTERS-1:0] m_req_ready,

  // master responses
  output logic [NUM_MASTERS-1:0] m_resp_valid,
  output data_t                  m_resp_data,
  input  logic [NUM_MASTERS-1:0] m_resp_ready
);

  // arbiter to bank
  logic  bank_req_valid;
  addr_t bank_req_addr;
  logic  bank_req_we;
  data_t bank_req_wdata;
  logic  bank_req_ready;

  // bank to arbiter
  logic  bank_resp_valid;
  data_t bank_resp_data;
  logic  bank_resp_ready;

  mem_arbiter i_mem_arbiter (
    .clk             (clk),
    .arst_n          (arst_n),
    .m_req_valid     (m_req_valid),
    .m_req_addr      (m_req_addr),
    .m_req_we        (m_req_we),
    .m_req_wdata     (m_req_wdata),
    .m_req_ready     (m_req_ready),
    .m_resp_valid    (m_resp_valid),
    .m_resp_data     (m_resp_data),
    .m_resp_ready    (m_resp_ready),
    .bank_req_valid  (bank_req_valid),
    .bank_req_addr   (bank_req_addr),
    .bank_req_we     (bank_req_we),
    .bank_req_wdata  (bank_req_wdata),
    .bank_req_ready  (bank_req_ready),
    .bank_resp_valid (bank_resp_valid),
    .bank_resp_data  (bank_resp_data),
    .bank_resp_ready (bank_resp_ready)
  );

  mem_bank i_mem_bank (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (bank_req_valid),
    .req_addr   (bank_req_addr),
    .req_we     (bank_req_we),
    .req_wdata  (bank_req_wdata),
    .req_ready  (bank_req_ready),
    .resp_valid (bank_resp_valid),
    .resp_data  (bank_resp_data),
    .resp_ready (bank_resp_ready)
  );

endmodule : mem_subsystem

/* verif/tb_clk_gen.sv */
// Testbench clock and reset, 10 ns period with reset held for two cycles.
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);        // release away from the active edge
    arst_n = 1'b1;
  end

endmodule : tb_clk_gen

/* verif/tb_mem_subsystem.sv */
// Testbench for the memory subsystem, random traffic from all masters against a shadow memory.
// Responses are checked for priority, data, routing order and the outstanding limit.
`timescale 1ns/1ps

module tb_mem_subsystem;
  import mem_pkg::*;
  import arb_pkg::*;

  typedef logic [NUM_MASTERS-1:0] master_vec_t;

  localparam int ADDR_SET    = 8;  // small address set so reads hit writes
  localparam int ADDR_STRIDE = 29;
  localparam int RAND_REQS   = 150;
  localparam int HOLD_REQS   = 40;
  localparam int HOLD_CYCLES = 16;
  localparam int NUM_REQS    = ADDR_SET + RAND_REQS + HOLD_REQS;
  localparam int TIMEOUT     = NUM_REQS * (NUM_MASTERS + 2) * 4;

  logic        clk;
  logic        arst_n;
  master_vec_t m_req_valid;
  addr_t       m_req_addr  [NUM_MASTERS];
  logic        m_req_we    [NUM_MASTERS];
  data_t       m_req_wdata [NUM_MASTERS];
  master_vec_t m_req_ready;
  master_vec_t m_resp_valid;
  data_t       m_resp_data;
  master_vec_t m_resp_ready;

  integer      seed;
  int          launched;   // requests raised by the driver
  int          req_count;  // request transfers seen
  int          resp_count; // response transfers seen
  int          cycles;     // cycles since reset release
  master_vec_t fired;      // set at the transfer edge, cleared by the driver

  data_t       shadow_mem [MEM_WORDS];
  data_t       exp_q      [NUM_MASTERS][$]; // expected data per master
  master_idx_t order_q    [$];              // expected response order

  tb_clk_gen i_tb_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  mem_subsystem i_mem_subsystem (
    .clk          (clk),
    .arst_n       (arst_n),
    .m_req_valid  (m_req_valid),
    .m_req_addr   (m_req_addr),
    .m_req_we     (m_req_we),
    .m_req_wdata  (m_req_wdata),
    .m_req_ready  (m_req_ready),
    .m_resp_valid (m_resp_valid),
    .m_resp_data  (m_resp_data),
    .m_resp_ready (m_resp_ready)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run("data mismatch");
    end
  endtask

  task automatic check_idx(input string name, input master_idx_t exp, input master_idx_t act);
    if (act !== exp) begin
      $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
      abort_run("master index mismatch");
    end
  endtask

  task automatic check_flags(input string name, input master_vec_t exp, input master_vec_t act);
    if (act !== exp) begin
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run("per-master flag mismatch");
    end
  endtask

  // fixed priority, lowest valid index wins
  function automatic master_idx_t lowest_valid(input master_vec_t valid);
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (valid[i]) begin
        return master_idx_t'(i);
      end
    end
    return '0;
  endfunction

  // reads give the last written word, writes echo their data
  function automatic data_t ref_access(input addr_t addr, input logic we, input data_t wdata);
    if (we) begin
      shadow_mem[addr] = wdata;
      return wdata;
    end
    return shadow_mem[addr];
  endfunction

  function automatic int rand_pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  function automatic bit queues_empty();
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (exp_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return order_q.size() == 0;
  endfunction

  task automatic drive_requests(input int pct);
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (fired[i]) begin
        fired[i]       = 1'b0;
        m_req_valid[i] = 1'b0;
      end
      if (!m_req_valid[i] && launched < NUM_REQS && rand_pct() < pct) begin
        m_req_valid[i] = 1'b1;
        m_req_addr[i]  = addr_t'((rand_pct() % ADDR_SET) * ADDR_STRIDE);
        m_req_we[i]    = rand_pct() < 40;
        m_req_wdata[i] = $random(seed);
        launched++;
      end
    end
  endtask

  task automatic drive_resp_ready(input int pct);
    for (int i = 0; i < NUM_MASTERS; i++) begin
      m_resp_ready[i] = rand_pct() < pct;
    end
  endtask

  // one write per address so no read sees an uninitialized word
  task automatic preload_writes();
    int m;
    for (int k = 0; k < ADDR_SET; k++) begin
      m = k % NUM_MASTERS;
      @(negedge clk);
      m_req_valid[m] = 1'b1;
      m_req_addr[m]  = addr_t'(k * ADDR_STRIDE);
      m_req_we[m]    = 1'b1;
      m_req_wdata[m] = $random(seed);
      launched++;
      while (!fired[m]) @(negedge clk);
      fired[m]       = 1'b0;
      m_req_valid[m] = 1'b0;
    end
  endtask

  always @(posedge clk) begin : monitor
    master_idx_t lowest;
    master_idx_t granted;
    if (!arst_n) begin
      check_flags("m_req_ready", '0, m_req_ready);
      check_flags("m_resp_valid", '0, m_resp_valid);
    end else begin
      cycles++;
      if (cycles <= 2) begin // just out of reset
        check_flags("m_req_ready", '0, m_req_ready);
        check_flags("m_resp_valid", '0, m_resp_valid);
      end
      if (cycles >= TIMEOUT) begin
        abort_run("timeout: requests did not complete within the cycle limit");
      end
      if ($countones(m_resp_valid) > 1) begin
        abort_run("response valid at more than one master in the same cycle");
      end
      for (int i = 0; i < NUM_MASTERS; i++) begin
        if (m_resp_valid[i]) begin
          if (order_q.size() == 0 || exp_q[i].size() == 0) begin
            abort_run("response valid at a master with no request outstanding");
          end
          check_idx("responding master", order_q[0], master_idx_t'(i));
          check_data("m_resp_data", exp_q[i][0], m_resp_data); // also while held
          if (m_resp_ready[i]) begin
            void'(exp_q[i].pop_front());
            void'(order_q.pop_front());
            resp_count++;
          end
        end
      end
      if ((m_req_valid & m_req_ready) != '0) begin
        lowest  = lowest_valid(m_req_valid);
        granted = '0;
        if ($countones(m_req_ready) != 1) begin
          abort_run("m_req_ready high at more than one master in the same cycle");
        end
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
          if (m_req_ready[i]) begin
            granted = master_idx_t'(i);
          end
        end
        check_idx("granted master", lowest, granted);
        exp_q[granted].push_back(ref_access(m_req_addr[granted], m_req_we[granted],
                                            m_req_wdata[granted]));
        order_q.push_back(granted);
        fired[granted] = 1'b1;
        req_count++;
      end
      if (req_count - resp_count > QUEUE_DEPTH) begin
        abort_run("more requests outstanding than the order queue can hold");
      end
    end
  end

  initial begin : stimulus
    seed         = 32'hf478;
    launched     = 0;
    req_count    = 0;
    resp_count   = 0;
    cycles       = 0;
    fired        = '0;
    m_req_valid  = '0;
    m_resp_ready = '0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      m_req_addr[i]  = '0;
      m_req_we[i]    = 1'b0;
      m_req_wdata[i] = '0;
    end

    @(posedge arst_n);
    repeat (2) @(negedge clk); // idle while outputs are checked low
    m_resp_ready = '1;
    preload_writes();

    // random traffic with random response back-pressure
    while (launched < ADDR_SET + RAND_REQS) begin
      @(negedge clk);
      drive_requests(50);
      drive_resp_ready(70);
    end

    // all masters busy, no master takes a response
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      drive_requests(100);
      m_resp_ready = '0;
    end

    do begin
      @(negedge clk);
      drive_requests(60);
      drive_resp_ready(70);
    end while (launched < NUM_REQS || m_req_valid != '0);

    while (resp_count != req_count) begin
      @(negedge clk);
      drive_resp_ready(70);
    end

    if (req_count == NUM_REQS && queues_empty()) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run("request count or expected-response queues wrong at end of run");
    end
  end

endmodule : tb_mem_subsystem
